/* rtl/opn_map_pkg.sv */
package opn_map_pkg;

	// ----------------------------------------------------------------------
	// Channel layout
	// ----------------------------------------------------------------------

	localparam int NUM_CH      = 6; // Channels in both banks together.
	localparam int CH_PER_BANK = 3; // Bank 1 holds channels 3 to 5.

	// ----------------------------------------------------------------------
	// Register map, low byte of the latched address
	// ----------------------------------------------------------------------

	localparam logic [7:0] ADDR_KEYON   = 8'h28;
	localparam logic [7:0] ADDR_FNUM_LO = 8'hA0; // Low two bits pick the channel.
	localparam logic [7:0] ADDR_FNUM_HI = 8'hA4; // Loads the shared high-byte latch.
	localparam logic [7:0] ADDR_FB_CON  = 8'hB0;
	localparam logic [7:0] ADDR_PAN_MS  = 8'hB4;

	// ----------------------------------------------------------------------
	// Field widths
	// ----------------------------------------------------------------------

	typedef logic [8:0]  reg_addr_t; // Bank in bit 8, register byte below.
	typedef logic [7:0]  reg_data_t;
	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;    // Octave.
	typedef logic [1:0]  note_t;
	typedef logic [2:0]  fb_t;
	typedef logic [2:0]  con_t;      // Operator connection algorithm.
	typedef logic [1:0]  pan_t;      // Left enable in bit 1, right in bit 0.
	typedef logic [1:0]  ams_t;
	typedef logic [2:0]  pms_t;
	typedef logic [3:0]  kon_t;      // One bit per operator slot.
	typedef logic [2:0]  ch_idx_t;

	// Kind of a decoded channel write.
	typedef enum logic [2:0] {
		FLD_NONE,
		FLD_FNUM,
		FLD_FB_CON,
		FLD_PAN_MS,
		FLD_KEYON
	} field_e;

endpackage

/* rtl/opn_bus_pkg.sv */
package opn_bus_pkg;

	import opn_map_pkg::*;

	// ----------------------------------------------------------------------
	// Host side
	// ----------------------------------------------------------------------

	// One data write, qualified by the stored address.
	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		reg_data_t data;
	} reg_wr_t;

	// ----------------------------------------------------------------------
	// Channel side
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic        valid;
		ch_idx_t     ch;
		field_e      fld;
		logic [10:0] payload; // Full fnum for FLD_FNUM, the data byte otherwise.
		block_t      block;   // Only meaningful with FLD_FNUM.
	} ch_wr_t;

	typedef struct packed {
		fnum_t  fnum;
		block_t block;
		fb_t    fb;
		con_t   con;
		pan_t   pan;
		ams_t   ams;
		pms_t   pms;
		kon_t   kon;
	} ch_regs_t;

	typedef struct packed {
		logic     valid;
		ch_idx_t  ch;
		ch_regs_t regs;
		note_t    note;
	} slot_t;

endpackage

/* rtl/opn_bus_port.sv */
`timescale 1ns/1ps

module opn_bus_port (
	input  logic                   mclk_i,
	input  logic                   arst_n_i,
	input  logic                   bus_req_i,
	input  logic                   bus_a0_i,
	input  logic                   bus_bank_i,
	input  opn_map_pkg::reg_data_t bus_data_i,
	output logic                   bus_ack_o,
	output opn_bus_pkg::reg_wr_t   wr_o
);

	import opn_map_pkg::*;

	typedef enum logic {
		BUS_IDLE,
		BUS_ACK
	} bus_state_e;

	bus_state_e state_q;
	reg_addr_t  addr_q;
	logic       addr_vld_q;
	reg_data_t  data_q;
	logic       strobe_q;
	logic       accept;
	logic       addr_ok;

	assign accept  = (state_q == BUS_IDLE) && bus_req_i; // New request this cycle.
	assign addr_ok = bus_data_i[7:4] != 4'h0;

	// ----------------------------------------------------------------------
	// Handshake and address register
	// ----------------------------------------------------------------------

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= BUS_IDLE;
			addr_q     <= '0;
			addr_vld_q <= 1'b0;
			strobe_q   <= 1'b0;
		end else begin
			strobe_q <= accept && bus_a0_i && addr_vld_q; // Same cycle as ack rises.
			case (state_q)
				BUS_IDLE: begin
					if (bus_req_i) begin
						state_q <= BUS_ACK;
					end
				end
				BUS_ACK: begin
					if (!bus_req_i) begin
						state_q <= BUS_IDLE;
					end
				end
				default: state_q <= BUS_IDLE;
			endcase
			if (accept && !bus_a0_i) begin
				addr_vld_q <= addr_ok; // A zero upper nibble blocks later data.
				if (addr_ok) begin
					addr_q <= {bus_bank_i, bus_data_i};
				end
			end
		end
	end

	// Data byte of the strobe.
	always_ff @(posedge mclk_i) begin
		if (accept && bus_a0_i) begin
			data_q <= bus_data_i;
		end
	end

	assign bus_ack_o = (state_q == BUS_ACK);

	assign wr_o = '{valid: strobe_q, addr: addr_q, data: data_q};

endmodule

/* rtl/opn_write_decode.sv */
`timescale 1ns/1ps

module opn_write_decode (
	input  logic                mclk_i,
	input  logic                arst_n_i,
	input  opn_bus_pkg::reg_wr_t wr_i,
	output opn_bus_pkg::ch_wr_t  ch_wr_o
);

	import opn_map_pkg::*;

	logic [7:0]  addr_byte;
	logic [1:0]  slot;
	ch_idx_t     bank_base;
	field_e      fld_d;
	ch_idx_t     ch_d;
	logic [10:0] payload_d;
	logic        fhi_load;
	logic [2:0]  fhi_fnum_q;  // Shared A4 latch, fnum bits 10:8.
	block_t      fhi_block_q;
	logic        valid_q;
	ch_idx_t     ch_q;
	field_e      fld_q;
	logic [10:0] payload_q;
	block_t      block_q;

	assign addr_byte = wr_i.addr[7:0];
	assign slot      = wr_i.addr[1:0];
	assign bank_base = wr_i.addr[8] ? ch_idx_t'(CH_PER_BANK) : '0;

	// ----------------------------------------------------------------------
	// Address classification
	// ----------------------------------------------------------------------

	always_comb begin
		fld_d     = FLD_NONE;
		ch_d      = bank_base + ch_idx_t'(slot);
		payload_d = {3'b000, wr_i.data};
		fhi_load  = 1'b0;
		if (wr_i.valid) begin
			if (addr_byte == ADDR_KEYON) begin
				// Key-on lives in bank 0 only and names its channel in the data.
				if (!wr_i.addr[8] && wr_i.data[1:0] != 2'd3) begin
					fld_d = FLD_KEYON;
					ch_d  = ch_idx_t'(wr_i.data[1:0]) +
						(wr_i.data[2] ? ch_idx_t'(CH_PER_BANK) : '0);
				end
			end else if (slot != 2'd3) begin
				case (addr_byte[7:2])
					ADDR_FNUM_LO[7:2]: begin
						fld_d     = FLD_FNUM;
						payload_d = {fhi_fnum_q, wr_i.data};
					end
					ADDR_FNUM_HI[7:2]: fhi_load = 1'b1;
					ADDR_FB_CON[7:2]:  fld_d = FLD_FB_CON;
					ADDR_PAN_MS[7:2]:  fld_d = FLD_PAN_MS;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q     <= 1'b0;
			fhi_fnum_q  <= '0;
			fhi_block_q <= '0;
		end else begin
			valid_q <= (fld_d != FLD_NONE);
			if (fhi_load) begin
				fhi_fnum_q  <= wr_i.data[2:0];
				fhi_block_q <= wr_i.data[5:3];
			end
		end
	end

	always_ff @(posedge mclk_i) begin
		ch_q      <= ch_d;
		fld_q     <= fld_d;
		payload_q <= payload_d;
		block_q   <= fhi_block_q; // Block travels with every A0 write.
	end

	assign ch_wr_o = '{valid: valid_q, ch: ch_q, fld: fld_q, payload: payload_q,
		block: block_q};

endmodule

/* rtl/opn_channel_regs.sv */
`timescale 1ns/1ps

module opn_channel_regs #(
	parameter int unsigned CH_INDEX = 0
) (
	input  logic                  mclk_i,
	input  logic                  arst_n_i,
	input  opn_bus_pkg::ch_wr_t   ch_wr_i,
	output opn_bus_pkg::ch_regs_t regs_o
);

	import opn_map_pkg::*;
	import opn_bus_pkg::*;

	ch_regs_t regs_q;
	logic     hit;
	logic     wr_fnum;
	logic     wr_fb_con;
	logic     wr_pan_ms;
	logic     wr_keyon;

	assign hit = ch_wr_i.valid && (ch_wr_i.ch == ch_idx_t'(CH_INDEX));

	assign wr_fnum   = hit && (ch_wr_i.fld == FLD_FNUM);
	assign wr_fb_con = hit && (ch_wr_i.fld == FLD_FB_CON);
	assign wr_pan_ms = hit && (ch_wr_i.fld == FLD_PAN_MS);
	assign wr_keyon  = hit && (ch_wr_i.fld == FLD_KEYON);

	// ----------------------------------------------------------------------
	// Field storage
	// ----------------------------------------------------------------------

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			regs_q <= '0;
		end else begin
			if (wr_fnum) begin
				regs_q.fnum  <= ch_wr_i.payload;
				regs_q.block <= ch_wr_i.block;
			end
			if (wr_fb_con) begin
				regs_q.fb  <= ch_wr_i.payload[5:3];
				regs_q.con <= ch_wr_i.payload[2:0];
			end
			if (wr_pan_ms) begin
				regs_q.pan <= ch_wr_i.payload[7:6];
				regs_q.ams <= ch_wr_i.payload[5:4];
				regs_q.pms <= ch_wr_i.payload[2:0]; // Bit 3 is unused.
			end
			if (wr_keyon) begin
				regs_q.kon <= ch_wr_i.payload[7:4];
			end
		end
	end

	assign regs_o = regs_q;

endmodule

/* rtl/opn_slot_scan.sv */
`timescale 1ns/1ps

module opn_slot_scan (
	input  logic                  mclk_i,
	input  logic                  arst_n_i,
	input  opn_bus_pkg::ch_regs_t regs_i [opn_map_pkg::NUM_CH],
	output opn_bus_pkg::slot_t    slot_o
);

	import opn_map_pkg::*;
	import opn_bus_pkg::*;

	ch_idx_t  cnt_q;
	ch_regs_t sel;
	fnum_t    sel_fnum;
	note_t    note;
	logic     valid_q;
	ch_idx_t  ch_q;
	ch_regs_t regs_q;
	note_t    note_q;

	assign sel      = regs_i[cnt_q];
	assign sel_fnum = sel.fnum;

	// Note code from the top four fnum bits.
	assign note[1] = sel_fnum[10];
	assign note[0] = sel_fnum[10] ? (sel_fnum[9:7] != 3'h0) : (sel_fnum[9:7] == 3'h7);

	// ----------------------------------------------------------------------
	// Channel counter and output register
	// ----------------------------------------------------------------------

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			if (cnt_q == ch_idx_t'(NUM_CH - 1)) begin
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 3'd1;
			end
			valid_q <= 1'b1; // Free running from the first cycle out of reset.
		end
	end

	always_ff @(posedge mclk_i) begin
		ch_q   <= cnt_q;
		regs_q <= sel;
		note_q <= note;
	end

	assign slot_o = '{valid: valid_q, ch: ch_q, regs: regs_q, note: note_q};

endmodule

/* rtl/opn_reg_top.sv */
`timescale 1ns/1ps

module opn_reg_top (
	input  logic                   mclk_i,
	input  logic                   arst_n_i,
	input  logic                   bus_req_i,
	input  logic                   bus_a0_i,
	input  logic                   bus_bank_i,
	input  opn_map_pkg::reg_data_t bus_data_i,
	output logic                   bus_ack_o,
	output opn_bus_pkg::slot_t     slot_o
);

	import opn_map_pkg::*;
	import opn_bus_pkg::*;

	reg_wr_t  bus_wr;
	ch_wr_t   ch_wr;
	ch_regs_t ch_regs [NUM_CH];

	opn_bus_port u_bus_port (
		.mclk_i     (mclk_i),
		.arst_n_i   (arst_n_i),
		.bus_req_i  (bus_req_i),
		.bus_a0_i   (bus_a0_i),
		.bus_bank_i (bus_bank_i),
		.bus_data_i (bus_data_i),
		.bus_ack_o  (bus_ack_o),
		.wr_o       (bus_wr)
	);

	opn_write_decode u_write_decode (
		.mclk_i   (mclk_i),
		.arst_n_i (arst_n_i),
		.wr_i     (bus_wr),
		.ch_wr_o  (ch_wr)
	);

	// ----------------------------------------------------------------------
	// Per-channel storage, all fed by the same decoded write
	// ----------------------------------------------------------------------

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		opn_channel_regs #(
			.CH_INDEX (i)
		) u_channel_regs (
			.mclk_i   (mclk_i),
			.arst_n_i (arst_n_i),
			.ch_wr_i  (ch_wr),
			.regs_o   (ch_regs[i])
		);
	end

	opn_slot_scan u_slot_scan (
		.mclk_i   (mclk_i),
		.arst_n_i (arst_n_i),
		.regs_i   (ch_regs),
		.slot_o   (slot_o)
	);

endmodule

/* testbench/opn_reg_model.svh */
`ifndef OPN_REG_MODEL_SVH
`define OPN_REG_MODEL_SVH

logic [31:0] rng_state = 32'd13;
ch_regs_t    exp_regs [NUM_CH];
logic [2:0]  exp_fhi_fnum;  // Shared high-byte latch.
block_t      exp_fhi_block;
reg_addr_t   exp_addr;
logic        exp_addr_vld;

function automatic logic [31:0] next_random();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

function automatic note_t expected_note(input fnum_t f);
	if (f[10]) begin
		return {1'b1, f[9:7] != 3'b000};
	end
	return {1'b0, f[9:7] == 3'b111};
endfunction

function void reset_model();
	for (int i = 0; i < NUM_CH; i++) begin
		exp_regs[i] = '0;
	end
	exp_fhi_fnum  = '0;
	exp_fhi_block = '0;
	exp_addr      = '0;
	exp_addr_vld  = 1'b0;
endfunction

// ----------------------------------------------------------------------
// Register map rules
// ----------------------------------------------------------------------

function void apply_register(input reg_addr_t addr, input reg_data_t data);
	logic [7:0] reg_byte;
	ch_idx_t    ch;
	reg_byte = addr[7:0];
	ch = (addr[8] ? 3'd3 : 3'd0) + ch_idx_t'(addr[1:0]);
	if (reg_byte == 8'h28) begin
		if (!addr[8] && data[1:0] != 2'd3) begin
			ch = ch_idx_t'(data[1:0]) + (data[2] ? 3'd3 : 3'd0); // Bit 2 picks bank 1.
			exp_regs[ch].kon = data[7:4];
		end
	end else if (reg_byte[1:0] != 2'd3) begin
		case (reg_byte & 8'hFC)
			8'hA0: begin
				exp_regs[ch].fnum  = {exp_fhi_fnum, data};
				exp_regs[ch].block = exp_fhi_block;
			end
			8'hA4: begin
				exp_fhi_fnum  = data[2:0];
				exp_fhi_block = data[5:3];
			end
			8'hB0: begin
				exp_regs[ch].fb  = data[5:3];
				exp_regs[ch].con = data[2:0];
			end
			8'hB4: begin
				exp_regs[ch].pan = data[7:6];
				exp_regs[ch].ams = data[5:4];
				exp_regs[ch].pms = data[2:0];
			end
			default: ;
		endcase
	end
endfunction

function void apply_write(input logic a0, input logic bank, input reg_data_t data);
	if (!a0) begin
		exp_addr_vld = (data[7:4] != 4'h0);
		if (exp_addr_vld) begin
			exp_addr = {bank, data};
		end
	end else if (exp_addr_vld) begin
		apply_register(exp_addr, data);
	end
endfunction

`endif

/* testbench/opn_reg_tb.sv */
`timescale 1ns/1ps

module opn_reg_tb;

	import opn_map_pkg::*;
	import opn_bus_pkg::*;

	`include "opn_reg_model.svh"

	localparam int HS_WRITES    = 40;
	localparam int FREQ_PAIRS   = 24;
	localparam int FIELD_WRITES = 30;
	localparam int KEYON_WRITES = 30;
	localparam int IGNORED_RUNS = 16;
	localparam int TOTAL_WRITES = HS_WRITES + 4 * FREQ_PAIRS + 2 * FIELD_WRITES +
		2 * KEYON_WRITES + 5 * IGNORED_RUNS;
	localparam int ACK_EDGES    = 2; // Falling edges until ack changes, counted from the drive.
	localparam logic [7:0] IGNORED_ADDR [5] = '{8'h30, 8'hA3, 8'hA7, 8'hB3, 8'hB7};

	logic      mclk = 1'b0;
	logic      arst_n;
	logic      bus_req;
	logic      bus_a0;
	logic      bus_bank;
	reg_data_t bus_data;
	logic      bus_ack;
	slot_t     slot;
	string     cur_test;
	int        test_errors;
	int        tests_passed;
	int        tests_failed;
	ch_regs_t  saved_regs [NUM_CH];

	opn_reg_top u_dut (
		.mclk_i     (mclk),
		.arst_n_i   (arst_n),
		.bus_req_i  (bus_req),
		.bus_a0_i   (bus_a0),
		.bus_bank_i (bus_bank),
		.bus_data_i (bus_data),
		.bus_ack_o  (bus_ack),
		.slot_o     (slot)
	);

	always #5 mclk = ~mclk;

	// ----------------------------------------------------------------------
	// Bus and check tasks
	// ----------------------------------------------------------------------

	task automatic bus_write(input logic a0, input logic bank, input reg_data_t data);
		int rise_wait;
		int fall_wait;
		@(posedge mclk);
		bus_req  <= 1'b1;
		bus_a0   <= a0;
		bus_bank <= bank;
		bus_data <= data;
		rise_wait = 0;
		do begin
			@(negedge mclk);
			rise_wait++;
		end while (!bus_ack);
		@(posedge mclk);
		bus_req <= 1'b0;
		fall_wait = 0;
		do begin
			@(negedge mclk);
			fall_wait++;
		end while (bus_ack);
		assert (rise_wait == ACK_EDGES) else begin
			$display("FAIL %s ack rise expected %0d actual %0d", cur_test, ACK_EDGES, rise_wait);
			test_errors++;
		end
		assert (fall_wait == ACK_EDGES) else begin
			$display("FAIL %s ack fall expected %0d actual %0d", cur_test, ACK_EDGES, fall_wait);
			test_errors++;
		end
		apply_write(a0, bank, data);
	endtask

	task automatic write_register(input logic bank, input reg_data_t addr, input reg_data_t data);
		bus_write(1'b0, bank, addr);
		bus_write(1'b1, bank, data);
	endtask

	task automatic write_channel(input ch_idx_t ch, input reg_data_t base, input reg_data_t data);
		logic    bank;
		ch_idx_t slot_no;
		bank    = (ch >= 3'd3);
		slot_no = bank ? ch - 3'd3 : ch;
		write_register(bank, base | {6'b0, slot_no[1:0]}, data);
	endtask

	task automatic check_slots();
		int                seen;
		ch_regs_t          exp;
		note_t             exp_note;
		logic [NUM_CH-1:0] seen_mask;
		repeat (10) @(posedge mclk);
		seen      = 0;
		seen_mask = '0;
		while (seen < NUM_CH) begin
			@(negedge mclk);
			if (slot.valid) begin
				seen++;
				assert (int'(slot.ch) < NUM_CH) else begin
					$display("Slot reported channel %0d, which does not exist", slot.ch);
					test_errors++;
				end
				if (int'(slot.ch) < NUM_CH) begin
					// Six consecutive slots must visit every channel once.
					assert (!seen_mask[slot.ch]) else begin
						$display("Channel %0d came twice within six slots", slot.ch);
						test_errors++;
					end
					seen_mask[slot.ch] = 1'b1;
					exp      = exp_regs[slot.ch];
					exp_note = expected_note(exp.fnum);
					assert (slot.regs == exp) else begin
						$display("FAIL %s ch %0d regs expected %h actual %h",
							cur_test, slot.ch, exp, slot.regs);
						test_errors++;
					end
					assert (slot.note == exp_note) else begin
						$display("FAIL %s ch %0d note expected %0d actual %0d",
							cur_test, slot.ch, exp_note, slot.note);
						test_errors++;
					end
				end
			end
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("test %s: pass", cur_test);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", cur_test, test_errors);
			tests_failed++;
		end
	endtask

	function automatic ch_idx_t pick_channel();
		return ch_idx_t'(next_random() % 32'd6);
	endfunction

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------

	initial begin
		arst_n       = 1'b0;
		bus_req      = 1'b0;
		bus_a0       = 1'b0;
		bus_bank     = 1'b0;
		bus_data     = '0;
		tests_passed = 0;
		tests_failed = 0;
		reset_model();
		repeat (16) @(posedge mclk);
		arst_n <= 1'b1;

		begin_test("reset");
		@(negedge mclk);
		assert (bus_ack == 1'b0) else begin
			$display("FAIL %s bus_ack expected 0 actual %0b", cur_test, bus_ack);
			test_errors++;
		end
		assert (slot.valid == 1'b0) else begin
			$display("FAIL %s slot valid expected 0 actual %0b", cur_test, slot.valid);
			test_errors++;
		end
		@(negedge mclk);
		assert (slot.valid == 1'b1) else begin
			$display("FAIL %s first slot valid expected 1 actual %0b", cur_test, slot.valid);
			test_errors++;
		end
		assert (slot.ch == 3'd0) else begin
			$display("FAIL %s first slot ch expected 0 actual %0d", cur_test, slot.ch);
			test_errors++;
		end
		check_slots();
		finish_test();

		begin_test("handshake");
		for (int i = 0; i < HS_WRITES; i++) begin
			logic [31:0] r;
			r = next_random();
			bus_write(r[0], r[1], r[15:8]);
		end
		check_slots();
		finish_test();

		begin_test("frequency");
		for (int i = 0; i < FREQ_PAIRS; i++) begin
			ch_idx_t     ch;
			logic [31:0] r;
			ch = pick_channel();
			r  = next_random();
			write_channel(ch, 8'hA4, r[7:0]);
			write_channel(ch, 8'hA0, r[15:8]);
		end
		check_slots();
		finish_test();

		begin_test("channel_fields");
		for (int i = 0; i < FIELD_WRITES; i++) begin
			logic [31:0] r;
			r = next_random();
			write_channel(pick_channel(), r[8] ? 8'hB4 : 8'hB0, r[7:0]);
		end
		check_slots();
		finish_test();

		begin_test("key_on");
		for (int i = 0; i < KEYON_WRITES; i++) begin
			logic [31:0] r;
			r = next_random();
			write_register(r[9] && r[10], 8'h28, r[7:0]); // Bank 1 now and then.
		end
		check_slots();
		finish_test();

		begin_test("ignored");
		saved_regs = exp_regs;
		for (int i = 0; i < IGNORED_RUNS; i++) begin
			logic [31:0] r;
			r = next_random();
			bus_write(1'b0, r[0], 8'hB0);
			bus_write(1'b0, r[0], {4'h0, r[11:8]});
			bus_write(1'b1, r[0], r[23:16]); // Dropped, the address is no longer valid.
			write_register(r[1], IGNORED_ADDR[int'(r[31:24]) % 5], r[7:0]);
		end
		for (int i = 0; i < NUM_CH; i++) begin
			assert (exp_regs[i] == saved_regs[i]) else begin
				$display("FAIL %s model ch %0d expected %h actual %h",
					cur_test, i, saved_regs[i], exp_regs[i]);
				test_errors++;
			end
		end
		check_slots();
		finish_test();

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		repeat (TOTAL_WRITES * 20 + 2000) @(posedge mclk);
		$display("The run timed out before all tests finished");
		$display("Testbench failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+testbench
rtl/opn_map_pkg.sv
rtl/opn_bus_pkg.sv
rtl/opn_bus_port.sv
rtl/opn_write_decode.sv
rtl/opn_channel_regs.sv
rtl/opn_slot_scan.sv
rtl/opn_reg_top.sv
testbench/opn_reg_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f \
	--top-module opn_reg_tb -Mdir obj_dir -o opn_reg_tb
if [ $? -ne 0 ]; then
	echo "Verilator compile step returned an error"
	exit 1
fi

./obj_dir/opn_reg_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi

exit 0
